//--- mem_stage.f
hdl/lsu_pkg.sv
hdl/wb_pkg.sv
hdl/mem_stage_reg.sv
hdl/store_format.sv
hdl/wb_data_master.sv
hdl/load_extend.sv
hdl/mem_stage.sv
verif/wb_mem_slave.sv
verif/mem_stage_tb.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - hdl/lsu_pkg.sv
  - hdl/wb_pkg.sv
  - hdl/mem_stage_reg.sv
  - hdl/store_format.sv
  - hdl/wb_data_master.sv
  - hdl/load_extend.sv
  - hdl/mem_stage.sv
  - target: test
    files:
      - verif/wb_mem_slave.sv
      - verif/mem_stage_tb.sv

//--- verif/mem_stage_tb.sv
// testbench for the memory stage with random ALU, load and store items from
// a fixed-seed xorshift stream, checked against a mirror memory model
// built from the project root with the file list and mem_stage_tb as top
`timescale 1ns/10ps
`default_nettype none

module mem_stage_tb;

    localparam int          num_items  = 400;
    localparam int          wait_limit = 200;
    localparam logic [31:0] win_base   = 32'h8000_0000;

    typedef struct packed {
        logic        we;
        logic [31:0] adr;
        logic [7:0]  sel;
        logic [63:0] dat;               // selected lanes only
    } bus_exp_t;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_ready;
    lsu_pkg::ex_req_t in_req;
    lsu_pkg::fwd_t    fwd;
    logic             out_valid;
    logic             out_ready;
    lsu_pkg::wb_res_t out_res;
    wb_pkg::wb_m2s_t  bus_m2s;
    wb_pkg::wb_s2m_t  bus_s2m;

    logic [63:0]      rng;
    logic [7:0]       mirror [0:255];
    lsu_pkg::wb_res_t res_q [$];
    bus_exp_t         bus_q [$];
    lsu_pkg::wb_res_t last_res;
    logic             last_stall;
    logic             acc;
    logic             timed_out;
    int               n_sent, n_mem_items, n_acks, n_checks, error_count;
    int               out_wait, ack_wait, cycles;

    mem_stage dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .fwd       (fwd),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res),
        .bus_o     (bus_m2s),
        .bus_i     (bus_s2m)
    );

    wb_mem_slave mem_i (
        .clk     (clk),
        .rst     (rst),
        .bus_m2s (bus_m2s),
        .bus_s2m (bus_s2m)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic int op_size(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: return 1;
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return 2;
            lsu_pkg::op_lw, lsu_pkg::op_lwu, lsu_pkg::op_sw: return 4;
            default:                                         return 8;
        endcase
    endfunction

    function automatic logic [63:0] lane_mask(input logic [7:0] sel);
        logic [63:0] m;
        int          k;
        m = '0;
        for (k = 0; k < 8; k++) begin
            if (sel[k]) begin
                m[8*k +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    task automatic make_item(output lsu_pkg::ex_req_t item);
        logic [63:0] r1;
        logic [63:0] r2;
        logic [2:0]  off;
        rng = xorshift64(rng);
        r1  = rng;
        rng = xorshift64(rng);
        r2  = rng;
        item.op   = lsu_pkg::mem_op_e'(r1[3:0] % 4'd12);
        item.pc   = {32'd0, r1[63:34], 2'b00};
        item.inst = r2[31:0];
        if (r2[33:32] == 2'b00) begin
            item.inst[24:20] = 5'd0;    // store from x0
        end
        off = r2[42:40] & 3'(~(op_size(item.op) - 1));  // naturally aligned
        item.alu_out = {32'd0, win_base[31:8], r2[39:35], off};
        rng = xorshift64(rng);
        if (item.op == lsu_pkg::op_alu) begin
            item.alu_out = rng;
        end
        rng = xorshift64(rng);
        item.src2 = rng;
    endtask

    // reference model of one accepted item
    task automatic accept_item(input lsu_pkg::ex_req_t item, input lsu_pkg::fwd_t f);
        lsu_pkg::wb_res_t res;
        bus_exp_t         be;
        logic [63:0]      src;
        logic [63:0]      v;
        logic             is_store;
        logic             is_load;
        int               size, a, off, k;
        size     = op_size(item.op);
        is_store = item.op inside {lsu_pkg::op_sb, lsu_pkg::op_sh,
                                   lsu_pkg::op_sw, lsu_pkg::op_sd};
        is_load  = (item.op != lsu_pkg::op_alu) && !is_store;
        a        = int'(item.alu_out[7:0]);
        off      = a % 8;
        res.pc      = item.pc;
        res.inst    = item.inst;
        res.rd      = item.inst[11:7];
        res.rd_we   = !is_store;
        res.rd_data = item.alu_out;
        be     = '0;
        be.we  = is_store;
        be.adr = {item.alu_out[31:3], 3'b000};
        src    = item.src2;
        if (f.valid && f.can_write && (f.rd == item.inst[24:20]) && (item.inst[24:20] != 0)) begin
            src = f.data;               // bypass from writeback
        end
        v = '0;
        for (k = 0; k < size; k++) begin
            if (is_store) begin
                mirror[a + k]               = src[8*k +: 8];
                be.sel[off + k]             = 1'b1;
                be.dat[8*(off + k) +: 8]    = src[8*k +: 8];
            end else begin
                v[8*k +: 8] = mirror[a + k];
            end
        end
        if (is_load) begin
            be.sel = 8'hff;
            if ((item.op inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw})
                    && v[8*size-1]) begin
                v = v | ~((64'd1 << (8*size)) - 64'd1);
            end
            res.rd_data = v;
        end
        res_q.push_back(res);
        if (item.op != lsu_pkg::op_alu) begin
            bus_q.push_back(be);
            n_mem_items++;
        end
    endtask

    task automatic drive_cycle(input logic send_more);
        lsu_pkg::fwd_t    f;
        lsu_pkg::ex_req_t item;
        logic [63:0]      r;
        @(posedge clk);
        rng = xorshift64(rng);
        r   = rng;
        rng = xorshift64(rng);
        f.valid     = r[0];
        f.can_write = r[1] | r[2];
        f.rd        = r[3] ? in_req.inst[24:20] : r[8:4];   // often hits rs2
        f.data      = rng;
        if (acc) begin
            accept_item(in_req, f);     // store sees this fwd in its first held cycle
            n_sent++;
        end
        fwd       <= f;
        out_ready <= !send_more || r[9] || r[10];
        if (!in_valid || acc) begin
            make_item(item);
            in_req   <= item;
            in_valid <= send_more && (n_sent < num_items) && (r[11] || r[12]);
        end
    endtask

    task automatic check_cycle();
        lsu_pkg::wb_res_t exp;
        bus_exp_t         be;
        @(negedge clk);
        acc = in_valid && in_ready;
        if (last_stall) begin
            assert (out_valid && (out_res == last_res)) else begin
                error_count++;
                $display("FAILED at %0t: out_res changed while stalled", $time);
            end
        end
        if (out_valid && out_ready) begin
            assert (res_q.size() != 0) else begin
                error_count++;
                $display("output at %0t while no item was outstanding", $time);
            end
            if (res_q.size() != 0) begin
                exp = res_q.pop_front();
                n_checks++;
                assert (out_res == exp) else begin
                    error_count++;
                    $display("FAILED at %0t: pc %h rd_data %h expected %h, rd_we %b expected %b",
                             $time, out_res.pc, out_res.rd_data, exp.rd_data,
                             out_res.rd_we, exp.rd_we);
                end
            end
        end
        last_stall = out_valid && !out_ready;
        last_res   = out_res;
        assert (bus_m2s.stb == bus_m2s.cyc) else begin
            error_count++;
            $display("FAILED at %0t: stb %b while cyc %b", $time, bus_m2s.stb, bus_m2s.cyc);
        end
        if (bus_m2s.cyc && bus_s2m.ack) begin
            n_acks++;
            ack_wait = 0;
            assert (bus_q.size() != 0) else begin
                error_count++;
                $display("bus access at %0t that no memory item asked for", $time);
            end
            if (bus_q.size() != 0) begin
                be = bus_q.pop_front();
                assert ((bus_m2s.we == be.we) && (bus_m2s.adr == be.adr)
                        && (bus_m2s.sel == be.sel)
                        && (!be.we || ((bus_m2s.dat & lane_mask(be.sel)) == be.dat))) else begin
                    error_count++;
                    $display("FAILED at %0t: bus adr %h sel %h dat %h expected %h %h %h",
                             $time, bus_m2s.adr, bus_m2s.sel, bus_m2s.dat,
                             be.adr, be.sel, be.dat);
                end
            end
        end else if (bus_m2s.cyc) begin
            ack_wait++;
        end else begin
            ack_wait = 0;
        end
        out_wait = ((res_q.size() != 0) && !out_valid) ? out_wait + 1 : 0;
        if ((out_wait > wait_limit || ack_wait > wait_limit) && !timed_out) begin
            timed_out = 1'b1;
            $display("timed out at %0t waiting %0d cycles for out_valid or ack",
                     $time, wait_limit);
        end
    endtask

    initial begin
        int i;
        rng = 64'd31120;
        for (i = 0; i < 256; i++) begin
            mirror[i] = 8'((i * 29) ^ (i >> 2) ^ 8'h3c);   // same fill as the memory
        end
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_req      = '0;
        fwd         = '0;
        out_ready   = 1'b0;
        last_stall  = 1'b0;
        acc         = 1'b0;
        timed_out   = 1'b0;
        n_sent      = 0;
        n_mem_items = 0;
        n_acks      = 0;
        n_checks    = 0;
        error_count = 0;
        out_wait    = 0;
        ack_wait    = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!out_valid && !bus_m2s.cyc && in_ready) else begin
            error_count++;
            $display("FAILED at %0t: state after reset out_valid %b cyc %b in_ready %b",
                     $time, out_valid, bus_m2s.cyc, in_ready);
        end
        cycles = 0;
        while (n_sent < num_items && !timed_out && cycles < num_items * 50) begin
            drive_cycle(1'b1);
            check_cycle();
            cycles++;
        end
        if (n_sent < num_items && !timed_out) begin
            timed_out = 1'b1;
            $display("timed out: only %0d of %0d items were accepted", n_sent, num_items);
        end
        cycles = 0;
        while ((res_q.size() != 0 || bus_q.size() != 0) && !timed_out
               && cycles < wait_limit) begin
            drive_cycle(1'b0);
            check_cycle();
            cycles++;
        end
        if (res_q.size() != 0 && !timed_out) begin
            timed_out = 1'b1;
            $display("timed out: %0d results never reached writeback", res_q.size());
        end
        assert (n_acks == n_mem_items) else begin
            error_count++;
            $display("FAILED at %0t: %0d acks for %0d memory items",
                     $time, n_acks, n_mem_items);
        end
        $display("items %0d, checks %0d, acks %0d, memory items %0d, errors %0d",
                 n_sent, n_checks, n_acks, n_mem_items, error_count);
        if (!timed_out && error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/wb_mem_slave.sv
// behavioral Wishbone classic memory for the memory stage testbench
// 256 bytes, registered ack after a random delay of 0 to 3 cycles
`timescale 1ns/10ps
`default_nettype none

module wb_mem_slave (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire wb_pkg::wb_m2s_t bus_m2s,
    output wb_pkg::wb_s2m_t      bus_s2m
);

    logic [7:0]  mem [0:255];
    logic [63:0] rng;
    logic        busy;              // delay already drawn for this access
    logic [1:0]  count;
    logic [1:0]  delay;
    logic [7:0]  base;
    integer      fill_idx;
    integer      lane;

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    initial begin
        rng = 64'd31120;
        for (fill_idx = 0; fill_idx < 256; fill_idx++) begin
            mem[fill_idx] = 8'((fill_idx * 29) ^ (fill_idx >> 2) ^ 8'h3c);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            bus_s2m.ack <= 1'b0;
            busy        <= 1'b0;
        end else if (bus_s2m.ack || !(bus_m2s.cyc && bus_m2s.stb)) begin
            bus_s2m.ack <= 1'b0;        // single beat, one ack per cycle
            busy        <= 1'b0;
        end else begin
            if (busy) begin
                delay = count;
            end else begin
                rng   = xorshift64(rng);
                delay = rng[1:0];
            end
            if (delay == 2'd0) begin
                base = {bus_m2s.adr[7:3], 3'b000};
                for (lane = 0; lane < 8; lane++) begin
                    bus_s2m.dat[8*lane +: 8] <= mem[base + lane];
                    if (bus_m2s.we && bus_m2s.sel[lane]) begin
                        mem[base + lane] <= bus_m2s.dat[8*lane +: 8];
                    end
                end
                bus_s2m.ack <= 1'b1;
                busy        <= 1'b0;
            end else begin
                busy  <= 1'b1;
                count <= delay - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
// memory access stage of the RV64 pipeline, between execute and writeback
// ALU results pass through; loads and stores run one Wishbone classic
// cycle each; valid/ready handshakes on both sides
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             in_valid,
    output logic                  in_ready,
    input  wire lsu_pkg::ex_req_t in_req,
    input  wire lsu_pkg::fwd_t    fwd,
    output logic                  out_valid,
    input  wire logic             out_ready,
    output lsu_pkg::wb_res_t      out_res,
    output wb_pkg::wb_m2s_t       bus_o,
    input  wire wb_pkg::wb_s2m_t  bus_i
);

    logic             held_valid;
    lsu_pkg::ex_req_t held_req;
    logic             needs_bus;
    logic             is_load;
    logic             bus_done;
    logic             leave;
    logic [63:0]      st_dat;
    logic [7:0]       st_sel;
    logic [63:0]      rd_word;
    logic [63:0]      ld_data;

    assign needs_bus = held_valid && (held_req.op != lsu_pkg::op_alu);
    assign is_load   = held_req.op inside {lsu_pkg::op_lb, lsu_pkg::op_lh,
                                           lsu_pkg::op_lw, lsu_pkg::op_ld,
                                           lsu_pkg::op_lbu, lsu_pkg::op_lhu,
                                           lsu_pkg::op_lwu};

    assign out_valid = held_valid && (!needs_bus || bus_done);
    assign leave     = out_valid && out_ready;
    assign in_ready  = !held_valid || leave;    // empty, or emptying now

    mem_stage_reg stage_reg_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .advance    (in_ready),
        .held_valid (held_valid),
        .held_req   (held_req)
    );

    store_format store_fmt_i (
        .req    (held_req),
        .fwd    (fwd),
        .st_dat (st_dat),
        .st_sel (st_sel)
    );

    wb_data_master bus_master_i (
        .clk     (clk),
        .rst     (rst),
        .valid   (needs_bus),
        .req     (held_req),
        .st_dat  (st_dat),
        .st_sel  (st_sel),
        .leave   (leave),
        .bus_o   (bus_o),
        .bus_i   (bus_i),
        .done    (bus_done),
        .rd_word (rd_word)
    );

    load_extend load_ext_i (
        .op      (held_req.op),
        .addr_lo (held_req.alu_out[2:0]),
        .word    (rd_word),
        .rd_data (ld_data)
    );

    assign out_res.pc      = held_req.pc;
    assign out_res.inst    = held_req.inst;
    assign out_res.rd_we   = (held_req.op == lsu_pkg::op_alu) || is_load;
    assign out_res.rd      = held_req.inst.r.rd;   // R-type view
    assign out_res.rd_data = is_load ? ld_data : held_req.alu_out;

endmodule

`default_nettype wire

//--- hdl/load_extend.sv
// load data formatting that takes the addressed byte, half or word out of
// the returned bus word and sign or zero extends it to a full register
`timescale 1ns/10ps
`default_nettype none

module load_extend (
    input  wire lsu_pkg::mem_op_e op,
    input  wire logic [2:0]       addr_lo,
    input  wire logic [63:0]      word,
    output logic [63:0]           rd_data
);

    logic [lsu_pkg::xlen-1:0] shifted;
    logic [7:0]               b;
    logic [15:0]              h;
    logic [31:0]              w;

    // addressed lane moved down to bit 0
    assign shifted = word >> {addr_lo, 3'b000};
    assign b = shifted[7:0];
    assign h = shifted[15:0];
    assign w = shifted[31:0];

    always_comb begin
        case (op)
            lsu_pkg::op_lb:  rd_data = {{56{b[7]}}, b};
            lsu_pkg::op_lh:  rd_data = {{48{h[15]}}, h};
            lsu_pkg::op_lw:  rd_data = {{32{w[31]}}, w};
            lsu_pkg::op_lbu: rd_data = {56'd0, b};
            lsu_pkg::op_lhu: rd_data = {48'd0, h};
            lsu_pkg::op_lwu: rd_data = {32'd0, w};
            default:         rd_data = word;    // ld, full word
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/wb_data_master.sv
// Wishbone classic master for the memory stage that runs one single-beat
// cycle per held load or store; done stays up until the item leaves so a
// stalled writeback never triggers a second access
`timescale 1ns/10ps
`default_nettype none

module wb_data_master (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             valid,
    input  wire lsu_pkg::ex_req_t req,
    input  wire logic [63:0]      st_dat,
    input  wire logic [7:0]       st_sel,
    input  wire logic             leave,
    output wb_pkg::wb_m2s_t       bus_o,
    input  wire wb_pkg::wb_s2m_t  bus_i,
    output logic                  done,
    output logic [63:0]           rd_word
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } state_e;

    state_e                    state;
    logic                      cyc_q;
    logic                      we_q;
    logic [wb_pkg::adr_w-1:0]  adr_q;
    logic [wb_pkg::dat_w-1:0]  dat_q;
    logic [wb_pkg::sel_w-1:0]  sel_q;
    logic                      is_store;
    logic                      start;

    assign is_store = req.op inside {lsu_pkg::op_sb, lsu_pkg::op_sh,
                                     lsu_pkg::op_sw, lsu_pkg::op_sd};
    assign start    = (state == st_idle) && valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cyc_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (valid) begin
                        state <= st_busy;
                        cyc_q <= 1'b1;      // cyc and stb together
                    end
                end
                st_busy: begin
                    if (bus_i.ack) begin
                        state <= st_done;
                        cyc_q <= 1'b0;
                    end
                end
                st_done: begin
                    if (leave) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request fields held stable for the whole cycle; lanes chosen by sel
    always_ff @(posedge clk) begin
        if (start) begin
            we_q  <= is_store;
            adr_q <= {req.alu_out[wb_pkg::adr_w-1:3], 3'b000};
            dat_q <= is_store ? st_dat : '0;
            sel_q <= is_store ? st_sel : '1;    // loads read the full word
        end
        if ((state == st_busy) && bus_i.ack) begin
            rd_word <= bus_i.dat;
        end
    end

    assign bus_o.cyc = cyc_q;
    assign bus_o.stb = cyc_q;
    assign bus_o.we  = we_q;
    assign bus_o.adr = adr_q;
    assign bus_o.dat = dat_q;
    assign bus_o.sel = sel_q;

    assign done = (state == st_done);

endmodule

`default_nettype wire

//--- hdl/store_format.sv
// store data path that picks the store value with bypass from writeback
// and moves it into the byte lanes given by the low address bits
// selects are zero for anything that is not a store
`timescale 1ns/10ps
`default_nettype none

module store_format (
    input  wire lsu_pkg::ex_req_t req,
    input  wire lsu_pkg::fwd_t    fwd,
    output logic [63:0]           st_dat,
    output logic [7:0]            st_sel
);

    logic [4:0]              rs2;
    logic                    fwd_hit;
    logic [lsu_pkg::xlen-1:0] src;
    logic [2:0]              lane;
    logic [5:0]              shamt;

    assign rs2 = req.inst.s.rs2;            // S-type view of the word

    // writeback result overrides the stale register value
    assign fwd_hit = fwd.valid && fwd.can_write
                     && (fwd.rd == rs2) && (rs2 != 5'd0);

    assign src   = fwd_hit ? fwd.data : req.src2;
    assign lane  = req.alu_out[2:0];
    assign shamt = {lane, 3'b000};          // lane index in bits

    always_comb begin
        case (req.op)
            lsu_pkg::op_sb: begin
                st_dat = {56'd0, src[7:0]} << shamt;
                st_sel = 8'h01 << lane;
            end
            lsu_pkg::op_sh: begin
                st_dat = {48'd0, src[15:0]} << shamt;
                st_sel = 8'h03 << lane;     // lane is even
            end
            lsu_pkg::op_sw: begin
                st_dat = {32'd0, src[31:0]} << shamt;
                st_sel = 8'h0f << lane;     // lane is 0 or 4
            end
            lsu_pkg::op_sd: begin
                st_dat = src;
                st_sel = 8'hff;
            end
            default: begin
                st_dat = '0;
                st_sel = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/mem_stage_reg.sv
// one-entry stage register between execute and the memory stage
// loads a new execute result on advance, otherwise holds the current one
`timescale 1ns/10ps
`default_nettype none

module mem_stage_reg (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             in_valid,
    input  wire lsu_pkg::ex_req_t in_req,
    input  wire logic             advance,
    output logic                  held_valid,
    output lsu_pkg::ex_req_t      held_req
);

    // occupancy flag
    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (advance) begin
            held_valid <= in_valid;         // empties if execute has nothing
        end
    end

    // payload loads together with the flag
    always_ff @(posedge clk) begin
        if (advance) begin
            held_req <= in_req;
        end
    end

endmodule

`default_nettype wire

//--- hdl/wb_pkg.sv
// Wishbone classic data bus widths and the two directions of the bus
// as packed structs, master-to-slave and slave-to-master
`default_nettype none

package wb_pkg;

    localparam int adr_w = 32;      // byte address
    localparam int dat_w = 64;
    localparam int sel_w = 8;       // one select per byte lane

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [adr_w-1:0] adr;
        logic [dat_w-1:0] dat;
        logic [sel_w-1:0] sel;
    } wb_m2s_t;

    typedef struct packed {
        logic [dat_w-1:0] dat;
        logic             ack;
    } wb_s2m_t;

endpackage

`default_nettype wire

//--- hdl/lsu_pkg.sv
// instruction formats, memory operation codes and stage boundary types
// shared by the memory stage RTL and its testbench through scoped names
`default_nettype none

package lsu_pkg;

    localparam int xlen = 64;       // one data word

    typedef enum logic [3:0] {
        op_alu = 4'd0,              // result passes straight to writeback
        op_lb  = 4'd1,
        op_lh  = 4'd2,
        op_lw  = 4'd3,
        op_ld  = 4'd4,
        op_lbu = 4'd5,
        op_lhu = 4'd6,
        op_lwu = 4'd7,
        op_sb  = 4'd8,
        op_sh  = 4'd9,
        op_sw  = 4'd10,
        op_sd  = 4'd11
    } mem_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // the same 32-bit word, read as R-type for rd and as S-type for rs2
    typedef union packed {
        r_fmt_t r;
        s_fmt_t s;
    } inst_u;

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_u           inst;
        mem_op_e         op;
        logic [xlen-1:0] alu_out;   // result or effective address
        logic [xlen-1:0] src2;      // store data
    } ex_req_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_u           inst;
        logic            rd_we;
        logic [4:0]      rd;
        logic [xlen-1:0] rd_data;
    } wb_res_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
        logic            can_write; // writeback instruction writes a register
    } fwd_t;

endpackage

`default_nettype wire
